// ==== tb.f ====
hdl/udp_flash_pkg.sv
hdl/mac_filter.sv
hdl/spi_flash_reader.sv
hdl/resp_fifo.sv
hdl/udp_cmd_ctrl.sv
hdl/udp_flash_server.sv
tb/spi_flash_model.sv
tb/tb_udp_flash_server.sv

// ==== run.sh ====
#!/bin/sh
# Build and run; the exit status is the simulation result
verilator --binary --timing -Wno-fatal --top-module tb_udp_flash_server \
    -f tb.f -o sim_tb_udp_flash_server \
    && ./obj_dir/sim_tb_udp_flash_server \
    || exit 1

// ==== tb/tb_udp_flash_server.sv ====
`default_nettype none

module tb_udp_flash_server
    import udp_flash_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [MAC_W-1:0] LOCAL_MAC = 48'h02_12_34_56_78_9A;
    localparam logic [MAC_W-1:0] BCAST_MAC = 48'hFFFF_FFFF_FFFF;
    localparam int CLK_NS      = 10;
    localparam int READ_CYCLES = 2 * (8 + 24 + 8 * 128);
    // Two reads at twice their nominal length plus the short commands
    localparam int WATCHDOG_NS = (4 * READ_CYCLES + 3000) * CLK_NS;

    logic              clk;
    logic              rst;
    logic              rx_hdr_valid;
    logic              rx_hdr_ready;
    logic [MAC_W-1:0]  rx_dest_mac;
    logic [IP_W-1:0]   rx_src_ip;
    logic [PORT_W-1:0] rx_src_port;
    logic [PORT_W-1:0] rx_dest_port;
    logic [PORT_W-1:0] rx_length;
    logic [BYTE_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_last;
    logic              rx_ready;
    logic              tx_hdr_valid;
    logic              tx_hdr_ready;
    logic [IP_W-1:0]   tx_dest_ip;
    logic [PORT_W-1:0] tx_src_port;
    logic [PORT_W-1:0] tx_dest_port;
    logic [PORT_W-1:0] tx_length;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_last;
    logic              tx_ready;
    logic [MAC_W-1:0]  local_mac;
    logic [IP_W-1:0]   local_ip;
    logic              spi_sck;
    logic              spi_mosi;
    logic              spi_miso;
    logic              spi_cs;

    logic [BYTE_W-1:0] payload[$];
    logic [BYTE_W-1:0] exp_bytes[$];

    udp_flash_server dut_i (.*);

    spi_flash_model flash_i (.*);

    always #(CLK_NS / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_byte(input string name, input logic [BYTE_W-1:0] got,
                                input logic [BYTE_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_port(input string name, input logic [PORT_W-1:0] got,
                                input logic [PORT_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_ip(input string name, input logic [IP_W-1:0] got,
                              input logic [IP_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_W-1:0] got,
                                input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // Header first, then the bytes queued in payload
    task automatic send_datagram(input logic [MAC_W-1:0] mac, input logic [IP_W-1:0] ip,
                                 input logic [PORT_W-1:0] sport,
                                 input logic [PORT_W-1:0] dport);
        bit accepted;
        rx_dest_mac  = mac;
        rx_src_ip    = ip;
        rx_src_port  = sport;
        rx_dest_port = dport;
        rx_length    = UDP_HDR_LEN + PORT_W'(payload.size());
        rx_hdr_valid = 1'b1;
        accepted     = 1'b0;
        while (!accepted) begin
            accepted = rx_hdr_ready;
            @(negedge clk);
        end
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < payload.size(); i++) begin
            rx_data  = payload[i];
            rx_last  = i == payload.size() - 1;
            rx_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                accepted = rx_ready;
                @(negedge clk);
            end
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    // Accepts one reply and checks it against exp_bytes
    task automatic collect_reply(input logic [IP_W-1:0] exp_ip,
                                 input logic [PORT_W-1:0] exp_src,
                                 input logic [PORT_W-1:0] exp_dst,
                                 input logic [PORT_W-1:0] exp_len, input bit bp);
        int idx;
        int stall;
        bit hdr_seen;
        idx      = 0;
        stall    = 0;
        hdr_seen = 1'b0;
        while (!hdr_seen) begin
            tx_hdr_ready = bp ? 1'($urandom) : 1'b1;
            if (tx_hdr_valid && tx_hdr_ready) begin
                compare_ip("tx_dest_ip", tx_dest_ip, exp_ip);
                compare_port("tx_src_port", tx_src_port, exp_src);
                compare_port("tx_dest_port", tx_dest_port, exp_dst);
                compare_port("tx_length", tx_length, exp_len);
                hdr_seen = 1'b1;
            end
            @(negedge clk);
        end
        tx_hdr_ready = 1'b0;
        while (idx < exp_bytes.size()) begin
            if (stall > 0) begin
                stall    = stall - 1;
                tx_ready = 1'b0;
            end else if (bp && $urandom % 6 == 0) begin
                stall    = int'(1 + $urandom % 24);
                tx_ready = 1'b0;
            end else begin
                tx_ready = 1'b1;
            end
            if (tx_ready && tx_valid) begin
                compare_byte($sformatf("tx_data[%0d]", idx), tx_data, exp_bytes[idx]);
                compare_flag("tx_last", tx_last, idx == exp_bytes.size() - 1);
                idx++;
            end
            @(negedge clk);
        end
        tx_ready = 1'b0;
    endtask

    // Command is over once rx_hdr_ready is back, with no reply pending
    task automatic wait_idle();
        bit idle;
        idle = 1'b0;
        while (!idle) begin
            compare_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
            idle = rx_hdr_ready;
            @(negedge clk);
        end
        compare_flag("tx_valid", tx_valid, 1'b0);
    endtask

    task automatic reset_state_check();
        compare_flag("rx_hdr_ready", rx_hdr_ready, 1'b1);
        compare_flag("rx_ready", rx_ready, 1'b0);
        compare_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
        compare_flag("tx_valid", tx_valid, 1'b0);
        compare_flag("spi_cs", spi_cs, 1'b1);
        compare_flag("spi_sck", spi_sck, 1'b0);
        compare_flag("reader done", dut_i.flash_i.done, 1'b0);
        compare_flag("reader rd_valid", dut_i.flash_i.rd_valid, 1'b0);
    endtask

    task automatic reflect_datagram(input logic [MAC_W-1:0] mac, input bit bp);
        logic [IP_W-1:0]   ip;
        logic [PORT_W-1:0] sport;
        logic [BYTE_W-1:0] b;
        ip    = $urandom;
        sport = PORT_W'($urandom);
        payload.delete();
        exp_bytes.delete();
        for (int i = 0; i < 20; i++) begin
            b = BYTE_W'($urandom);
            payload.push_back(b);
            exp_bytes.push_back(b);
        end
        fork
            send_datagram(mac, ip, sport, REFLECT_PORT);
            collect_reply(ip, 16'd1234, sport, 16'd28, bp);
        join
        wait_idle();
    endtask

    task automatic dropped_datagrams();
        payload.delete();
        for (int i = 0; i < 6; i++) begin
            payload.push_back(BYTE_W'($urandom));
        end
        // One MAC bit off
        send_datagram(LOCAL_MAC ^ 48'h1, $urandom, PORT_W'($urandom), REFLECT_PORT);
        wait_idle();
        send_datagram(LOCAL_MAC, $urandom, PORT_W'($urandom), 16'd5555);
        wait_idle();
    endtask

    task automatic flash_read_reply(input bit bp, input int extra);
        logic [ADDR_W-1:0] addr;
        logic [IP_W-1:0]   ip;
        logic [PORT_W-1:0] sport;
        addr  = ADDR_W'($urandom);
        ip    = $urandom;
        sport = PORT_W'($urandom);
        payload.delete();
        payload.push_back(addr[7:0]);
        payload.push_back(addr[15:8]);
        payload.push_back(addr[23:16]);
        for (int i = 0; i < extra; i++) begin
            payload.push_back(BYTE_W'($urandom));
        end
        exp_bytes.delete();
        for (int i = 0; i < 128; i++) begin
            exp_bytes.push_back((addr[7:0] + 8'(i)) ^ 8'h5A);
        end
        fork
            send_datagram(LOCAL_MAC, ip, sport, FLASH_READ_PORT);
            collect_reply(ip, 16'hEEE0, 16'hEEE1, 16'd136, bp);
        join
        wait_idle();
    endtask

    task automatic flash_erase_cmd();
        int                count_before;
        logic [ADDR_W-1:0] addr;
        count_before = flash_i.erase_count;
        addr         = ADDR_W'($urandom);
        payload.delete();
        payload.push_back(addr[7:0]);
        payload.push_back(addr[15:8]);
        payload.push_back(addr[23:16]);
        // Surplus bytes get drained
        payload.push_back(BYTE_W'($urandom));
        payload.push_back(BYTE_W'($urandom));
        send_datagram(LOCAL_MAC, $urandom, PORT_W'($urandom), FLASH_ERASE_PORT);
        wait_idle();
        if (flash_i.erase_error) begin
            abort_run("Flash model saw a sector erase without a write enable before it");
        end
        if (flash_i.erase_count != count_before + 1) begin
            abort_run("Flash model did not record exactly one sector erase");
        end
        compare_addr("erased address", flash_i.erase_addr, addr);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: tests still running after %0d ns", WATCHDOG_NS));
    end

    initial begin
        void'($urandom(56261));
        clk          = 1'b0;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_dest_mac  = '0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dest_port = '0;
        rx_length    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_ready     = 1'b0;
        local_mac    = LOCAL_MAC;
        local_ip     = 32'hC0A8_010A;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_state_check();
        reflect_datagram(LOCAL_MAC, 1'b0);
        reflect_datagram(BCAST_MAC, 1'b0);
        dropped_datagrams();
        flash_read_reply(1'b0, 0);
        flash_erase_cmd();
        reflect_datagram(LOCAL_MAC, 1'b1);
        flash_read_reply(1'b1, 4);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/spi_flash_model.sv ====
`default_nettype none

module spi_flash_model
    import udp_flash_pkg::*;
(
    input  wire  spi_sck,
    input  wire  spi_mosi,
    input  wire  spi_cs,
    output logic spi_miso
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]       shift_in = '0;
    int                rx_bits = 0;
    logic              wel = 1'b0;
    // Last accepted sector erase
    logic [ADDR_W-1:0] erase_addr = '0;
    int                erase_count = 0;
    logic              erase_error = 1'b0;
    logic              read_mode = 1'b0;
    logic [ADDR_W-1:0] rd_addr = '0;
    int                out_idx = 0;
    logic [BYTE_W-1:0] out_byte;
    logic              miso_q = 1'b0;

    assign spi_miso = miso_q;

    // Commands shift in on the rising edge, cs rising ends a command
    always @(posedge spi_sck or posedge spi_cs) begin
        if (spi_cs) begin
            if (rx_bits == 8 && shift_in[7:0] == OP_WREN) begin
                wel <= 1'b1;
            end else if (rx_bits == 32 && shift_in[31:24] == OP_SECTOR_ERASE) begin
                if (wel) begin
                    erase_addr  <= shift_in[23:0];
                    erase_count <= erase_count + 1;
                end else begin
                    erase_error <= 1'b1;
                end
                wel <= 1'b0;
            end
            rx_bits <= 0;
        end else begin
            shift_in <= {shift_in[30:0], spi_mosi};
            rx_bits  <= rx_bits + 1;
        end
    end

    // Read data goes out after each falling edge, MSB first
    always @(negedge spi_sck) begin
        if (rx_bits < 32) begin
            read_mode = 1'b0;
        end else if (rx_bits == 32) begin
            read_mode = shift_in[31:24] == OP_READ;
            rd_addr   = shift_in[23:0];
            out_idx   = 0;
        end
        if (read_mode && !spi_cs) begin
            out_byte = (rd_addr[7:0] + 8'(out_idx / 8)) ^ 8'h5A;
            miso_q  <= out_byte[7 - out_idx % 8];
            out_idx  = out_idx + 1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_flash_server.sv ====
`default_nettype none

module udp_flash_server
    import udp_flash_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  wire [MAC_W-1:0]   rx_dest_mac,
    input  wire [IP_W-1:0]    rx_src_ip,
    input  wire [PORT_W-1:0]  rx_src_port,
    input  wire [PORT_W-1:0]  rx_dest_port,
    input  wire [PORT_W-1:0]  rx_length,
    input  wire [BYTE_W-1:0]  rx_data,
    input  wire               rx_valid,
    input  wire               rx_last,
    output logic              rx_ready,
    output logic              tx_hdr_valid,
    input  wire               tx_hdr_ready,
    output logic [IP_W-1:0]   tx_dest_ip,
    output logic [PORT_W-1:0] tx_src_port,
    output logic [PORT_W-1:0] tx_dest_port,
    output logic [PORT_W-1:0] tx_length,
    output logic [BYTE_W-1:0] tx_data,
    output logic              tx_valid,
    output logic              tx_last,
    input  wire               tx_ready,
    input  wire [MAC_W-1:0]   local_mac,
    input  wire [IP_W-1:0]    local_ip,
    output logic              spi_sck,
    output logic              spi_mosi,
    input  wire               spi_miso,
    output logic              spi_cs
);

    logic              sample;
    logic              match_valid;
    logic              match;
    logic              read_start;
    logic              erase_start;
    logic [ADDR_W-1:0] flash_addr;
    logic [BYTE_W-1:0] rd_data;
    logic              rd_valid;
    logic              rd_ready;
    logic              done;
    logic [BYTE_W-1:0] fifo_wr_data;
    logic              fifo_wr_last;
    logic              fifo_wr_valid;
    logic              fifo_wr_ready;

    udp_cmd_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_src_ip     (rx_src_ip),
        .rx_src_port   (rx_src_port),
        .rx_dest_port  (rx_dest_port),
        .rx_length     (rx_length),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_last       (rx_last),
        .rx_ready      (rx_ready),
        .local_ip      (local_ip),
        .sample        (sample),
        .match_valid   (match_valid),
        .match         (match),
        .read_start    (read_start),
        .erase_start   (erase_start),
        .flash_addr    (flash_addr),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .done          (done),
        .fifo_wr_data  (fifo_wr_data),
        .fifo_wr_last  (fifo_wr_last),
        .fifo_wr_valid (fifo_wr_valid),
        .fifo_wr_ready (fifo_wr_ready),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_dest_ip    (tx_dest_ip),
        .tx_src_port   (tx_src_port),
        .tx_dest_port  (tx_dest_port),
        .tx_length     (tx_length)
    );

    // Destination MAC is sampled on the header accept cycle
    mac_filter filter_i (
        .clk         (clk),
        .rst         (rst),
        .sample      (sample),
        .dest_mac    (rx_dest_mac),
        .local_mac   (local_mac),
        .match_valid (match_valid),
        .match       (match)
    );

    spi_flash_reader flash_i (
        .clk         (clk),
        .rst         (rst),
        .read_start  (read_start),
        .erase_start (erase_start),
        .flash_addr  (flash_addr),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .rd_ready    (rd_ready),
        .done        (done),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .spi_cs      (spi_cs)
    );

    resp_fifo fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (fifo_wr_data),
        .wr_last  (fifo_wr_last),
        .wr_valid (fifo_wr_valid),
        .wr_ready (fifo_wr_ready),
        .rd_data  (tx_data),
        .rd_last  (tx_last),
        .rd_valid (tx_valid),
        .rd_ready (tx_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/udp_cmd_ctrl.sv ====
`default_nettype none

module udp_cmd_ctrl
    import udp_flash_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  wire [IP_W-1:0]    rx_src_ip,
    input  wire [PORT_W-1:0]  rx_src_port,
    input  wire [PORT_W-1:0]  rx_dest_port,
    input  wire [PORT_W-1:0]  rx_length,
    input  wire [BYTE_W-1:0]  rx_data,
    input  wire               rx_valid,
    input  wire               rx_last,
    output logic              rx_ready,
    // Source IP of a reply is filled in by the UDP stack
    input  wire [IP_W-1:0]    local_ip,
    output logic              sample,
    input  wire               match_valid,
    input  wire               match,
    output logic              read_start,
    output logic              erase_start,
    output logic [ADDR_W-1:0] flash_addr,
    input  wire [BYTE_W-1:0]  rd_data,
    input  wire               rd_valid,
    output logic              rd_ready,
    input  wire               done,
    output logic [BYTE_W-1:0] fifo_wr_data,
    output logic              fifo_wr_last,
    output logic              fifo_wr_valid,
    input  wire               fifo_wr_ready,
    output logic              tx_hdr_valid,
    input  wire               tx_hdr_ready,
    output logic [IP_W-1:0]   tx_dest_ip,
    output logic [PORT_W-1:0] tx_src_port,
    output logic [PORT_W-1:0] tx_dest_port,
    output logic [PORT_W-1:0] tx_length
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_MATCH   = 3'd1;
    localparam logic [2:0] ST_ADDR    = 3'd2;
    localparam logic [2:0] ST_REFLECT = 3'd3;
    localparam logic [2:0] ST_READ    = 3'd4;
    localparam logic [2:0] ST_ERASE   = 3'd5;
    localparam logic [2:0] ST_DRAIN   = 3'd6;
    localparam logic [2:0] ST_FINISH  = 3'd7;

    logic [2:0] state;
    logic       is_read;
    logic [1:0] addr_cnt;
    logic       rx_done;
    logic [6:0] rd_cnt;

    assign sample = rx_hdr_valid && rx_hdr_ready;

    // Payload source for the reply FIFO
    always_comb begin
        fifo_wr_data  = rx_data;
        fifo_wr_last  = rx_last;
        fifo_wr_valid = 1'b0;
        rd_ready      = 1'b0;
        rx_ready      = 1'b0;
        case (state)
            ST_REFLECT: begin
                fifo_wr_valid = rx_valid;
                rx_ready      = fifo_wr_ready;
            end
            ST_READ: begin
                fifo_wr_data  = rd_data;
                fifo_wr_last  = rd_cnt == 7'(READ_LEN - 1);
                fifo_wr_valid = rd_valid;
                rd_ready      = fifo_wr_ready;
            end
            ST_ADDR, ST_DRAIN: rx_ready = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            rx_hdr_ready <= 1'b1;
            tx_hdr_valid <= 1'b0;
            read_start   <= 1'b0;
            erase_start  <= 1'b0;
            is_read      <= 1'b0;
            addr_cnt     <= 2'd0;
            rx_done      <= 1'b0;
            rd_cnt       <= 7'd0;
        end else begin
            read_start  <= 1'b0;
            erase_start <= 1'b0;
            if (tx_hdr_valid && tx_hdr_ready) begin
                tx_hdr_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (sample) begin
                        // Reply source port is the command port
                        tx_dest_ip   <= rx_src_ip;
                        tx_src_port  <= rx_dest_port;
                        tx_dest_port <= rx_src_port;
                        tx_length    <= rx_length;
                        rx_hdr_ready <= 1'b0;
                        addr_cnt     <= 2'd0;
                        rx_done      <= 1'b0;
                        state        <= ST_MATCH;
                    end
                end
                ST_MATCH: begin
                    if (match_valid) begin
                        if (!match) begin
                            state <= ST_DRAIN;
                        end else begin
                            case (tx_src_port)
                                REFLECT_PORT: begin
                                    tx_hdr_valid <= 1'b1;
                                    state        <= ST_REFLECT;
                                end
                                FLASH_READ_PORT: begin
                                    is_read <= 1'b1;
                                    state   <= ST_ADDR;
                                end
                                FLASH_ERASE_PORT: begin
                                    is_read <= 1'b0;
                                    state   <= ST_ADDR;
                                end
                                default: state <= ST_DRAIN;
                            endcase
                        end
                    end
                end
                ST_ADDR: begin
                    if (rx_valid) begin
                        // Address arrives LSB first
                        flash_addr <= {rx_data, flash_addr[ADDR_W-1:BYTE_W]};
                        addr_cnt   <= addr_cnt + 2'd1;
                        rx_done    <= rx_last;
                        if (addr_cnt == 2'd2) begin
                            if (is_read) begin
                                tx_dest_port <= FLASH_READ_REPLY_PORT;
                                tx_length    <= READ_LEN + UDP_HDR_LEN;
                                tx_hdr_valid <= 1'b1;
                                read_start   <= 1'b1;
                                rd_cnt       <= 7'd0;
                                state        <= ST_READ;
                            end else begin
                                erase_start <= 1'b1;
                                state       <= ST_ERASE;
                            end
                        end else if (rx_last) begin
                            // Address too short, nothing to do
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_REFLECT: begin
                    if (rx_valid && fifo_wr_ready && rx_last) begin
                        state <= ST_FINISH;
                    end
                end
                ST_READ: begin
                    if (rd_valid && fifo_wr_ready) begin
                        rd_cnt <= rd_cnt + 7'd1;
                    end
                    if (done) begin
                        state <= rx_done ? ST_FINISH : ST_DRAIN;
                    end
                end
                ST_ERASE: begin
                    if (done) begin
                        state <= rx_done ? ST_FINISH : ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (rx_valid && rx_last) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (!tx_hdr_valid) begin
                        rx_hdr_ready <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/resp_fifo.sv ====
`default_nettype none

module resp_fifo
    import udp_flash_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire [BYTE_W-1:0]  wr_data,
    input  wire               wr_last,
    input  wire               wr_valid,
    output logic              wr_ready,
    output logic [BYTE_W-1:0] rd_data,
    output logic              rd_last,
    output logic              rd_valid,
    input  wire               rd_ready
);

    // Each entry carries the byte and its last flag
    logic [BYTE_W:0]                 mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]     count;
    logic                            push;
    logic                            pop;

    assign wr_ready = count != FIFO_DEPTH;
    assign rd_valid = count != 0;
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;
    assign {rd_last, rd_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_flash_reader.sv ====
`default_nettype none

module spi_flash_reader
    import udp_flash_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               read_start,
    input  wire               erase_start,
    input  wire [ADDR_W-1:0]  flash_addr,
    output logic [BYTE_W-1:0] rd_data,
    output logic              rd_valid,
    input  wire               rd_ready,
    output logic              done,
    output logic              spi_sck,
    output logic              spi_mosi,
    input  wire               spi_miso,
    output logic              spi_cs
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CMD  = 3'd1;
    localparam logic [2:0] ST_DATA = 3'd2;
    localparam logic [2:0] ST_GAP  = 3'd3;
    localparam logic [2:0] ST_FIN  = 3'd4;

    logic [2:0]               state;
    logic [BYTE_W+ADDR_W-1:0] shift_reg;
    logic [5:0]               bit_cnt;
    logic                     is_read;
    logic                     erase_next;
    logic                     gap_wait;
    logic [2:0]               bit_in;
    logic [7:0]               byte_cnt;
    logic [BYTE_W-1:0]        rx_shift;

    // Opcode and address go out MSB first
    assign spi_mosi = shift_reg[BYTE_W+ADDR_W-1] & ~spi_cs;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            spi_cs     <= 1'b1;
            spi_sck    <= 1'b0;
            rd_valid   <= 1'b0;
            done       <= 1'b0;
            is_read    <= 1'b0;
            erase_next <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rd_valid && rd_ready) begin
                rd_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (read_start) begin
                        shift_reg <= {OP_READ, flash_addr};
                        bit_cnt   <= 6'd32;
                        is_read   <= 1'b1;
                        spi_cs    <= 1'b0;
                        state     <= ST_CMD;
                    end else if (erase_start) begin
                        // Write enable first, erase after the gap
                        shift_reg  <= {OP_WREN, {ADDR_W{1'b0}}};
                        bit_cnt    <= 6'd8;
                        is_read    <= 1'b0;
                        erase_next <= 1'b1;
                        spi_cs     <= 1'b0;
                        state      <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    spi_sck <= ~spi_sck;
                    if (spi_sck) begin
                        shift_reg <= {shift_reg[BYTE_W+ADDR_W-2:0], 1'b0};
                        bit_cnt   <= bit_cnt - 6'd1;
                        if (bit_cnt == 6'd1) begin
                            if (is_read) begin
                                bit_in   <= 3'd0;
                                byte_cnt <= 8'd0;
                                state    <= ST_DATA;
                            end else begin
                                spi_cs   <= 1'b1;
                                gap_wait <= 1'b0;
                                state    <= erase_next ? ST_GAP : ST_FIN;
                            end
                        end
                    end
                end
                ST_DATA: begin
                    if (!spi_sck) begin
                        // Hold sck low while a byte is still waiting
                        if (!rd_valid) begin
                            spi_sck  <= 1'b1;
                            rx_shift <= {rx_shift[BYTE_W-2:0], spi_miso};
                            bit_in   <= bit_in + 3'd1;
                            if (bit_in == 3'd7) begin
                                rd_data  <= {rx_shift[BYTE_W-2:0], spi_miso};
                                rd_valid <= 1'b1;
                                byte_cnt <= byte_cnt + 8'd1;
                            end
                        end
                    end else begin
                        spi_sck <= 1'b0;
                        if (bit_in == 3'd0 && byte_cnt == READ_LEN[7:0]) begin
                            spi_cs <= 1'b1;
                            state  <= ST_FIN;
                        end
                    end
                end
                ST_GAP: begin
                    gap_wait <= 1'b1;
                    if (gap_wait) begin
                        shift_reg  <= {OP_SECTOR_ERASE, flash_addr};
                        bit_cnt    <= 6'd32;
                        erase_next <= 1'b0;
                        spi_cs     <= 1'b0;
                        state      <= ST_CMD;
                    end
                end
                ST_FIN: begin
                    if (!rd_valid) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mac_filter.sv ====
`default_nettype none

module mac_filter
    import udp_flash_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              sample,
    input  wire [MAC_W-1:0]  dest_mac,
    input  wire [MAC_W-1:0]  local_mac,
    output logic             match_valid,
    output logic             match
);

    logic [MAC_W/4-1:0]  nib_eq;
    logic [MAC_W/12-1:0] bcast;
    logic                stage1_valid;

    // Stage 1 splits the 48-bit compare into small pieces
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAC_W / 4; i++) begin
            nib_eq[i] <= dest_mac[4*i +: 4] == local_mac[4*i +: 4];
        end
        for (int j = 0; j < MAC_W / 12; j++) begin
            bcast[j] <= &dest_mac[12*j +: 12];
        end
        match <= (&nib_eq) | (&bcast);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            match_valid  <= 1'b0;
        end else begin
            stage1_valid <= sample;
            match_valid  <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_flash_pkg.sv ====
`default_nettype none

package udp_flash_pkg;

    // Bus widths
    localparam int MAC_W  = 48;
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;
    localparam int ADDR_W = 24;
    localparam int BYTE_W = 8;

    // UDP command ports
    localparam logic [PORT_W-1:0] REFLECT_PORT          = 16'd1234;
    localparam logic [PORT_W-1:0] FLASH_READ_PORT       = 16'hEEE0;
    localparam logic [PORT_W-1:0] FLASH_READ_REPLY_PORT = 16'hEEE1;
    localparam logic [PORT_W-1:0] FLASH_ERASE_PORT      = 16'hEEEE;

    // Reply sizes
    localparam logic [PORT_W-1:0] READ_LEN    = 16'd128;
    localparam logic [PORT_W-1:0] UDP_HDR_LEN = 16'd8;

    // SPI flash opcodes
    localparam logic [BYTE_W-1:0] OP_READ         = 8'h03;
    localparam logic [BYTE_W-1:0] OP_WREN         = 8'h06;
    localparam logic [BYTE_W-1:0] OP_SECTOR_ERASE = 8'h20;

    localparam int FIFO_DEPTH = 16;

endpackage

`default_nettype wire
